// File: exc_settings.svh
`ifndef EXC_SETTINGS_SVH
`define EXC_SETTINGS_SVH

// vector base while Status.BEV is set, the boot ROM region
`define EXC_BOOT_BASE       32'hbfc00200

// Ebase after reset, start of kseg0
`define EXC_RESET_EBASE     32'h80000000

// offset of the general exception vector
`define EXC_OFFSET_GENERAL  32'h00000180

// offset of the TLB refill vector, used only when EXL was clear
`define EXC_OFFSET_REFILL   32'h00000000

// Status after reset
// bit 22 BEV set, bit 1 EXL clear, bit 0 IE clear
`define EXC_RESET_STATUS    32'h00400000

`endif

// File: excPkg.sv
`default_nettype none

package excPkg;

    // flags gathered by fetch, decode and execute
    typedef struct packed {
        logic refetch;
        logic wrongAddrIf;
        logic tlbRefillIf;
        logic tlbInvalidIf;
        logic cpUnusable;
        logic reservedInstr;
        logic syscall;
        logic brk;
        logic eret;
        logic trap;
        logic overflow;
        logic wrWrongAddrMem;
        logic rdWrongAddrMem;
        logic spare;
    } excFlagsT;

    // data side TLB result, at most one per record
    typedef enum logic [2:0] {
        tlbNone      = 3'd0,
        tlbRdRefill  = 3'd1,
        tlbRdInvalid = 3'd2,
        tlbWrRefill  = 3'd3,
        tlbWrInvalid = 3'd4,
        tlbModified  = 3'd5
    } tlbFaultT;

    typedef enum logic [4:0] {
        excInt     = 5'd0,
        excMod     = 5'd1,
        excTlbl    = 5'd2,
        excTlbs    = 5'd3,
        excAdel    = 5'd4,
        excAdes    = 5'd5,
        excSys     = 5'd8,
        excBp      = 5'd9,
        excRi      = 5'd10,
        excCpu     = 5'd11,
        excOv      = 5'd12,
        excTr      = 5'd13,
        excRefetch = 5'd29,  // internal, never written to Cause
        excEret    = 5'd30,  // internal
        excNone    = 5'd31   // internal
    } excCodeT;

    // CP0 register numbers reachable by mtc0
    typedef enum logic [4:0] {
        cp0Status = 5'd12,
        cp0Cause  = 5'd13,
        cp0Epc    = 5'd14,
        cp0Ebase  = 5'd15    // select 1 implied
    } cp0RegT;

    typedef struct packed {
        logic        en;
        cp0RegT      sel;
        logic [31:0] data;
    } cp0WriteT;

    typedef struct packed {
        logic [31:0] pc;
        excFlagsT    flags;
        tlbFaultT    tlbFault;
        logic [31:0] badAddr;
        logic        inDelaySlot;
        cp0WriteT    cp0Write;
    } memRecordT;

    typedef enum logic [1:0] {
        retCommit    = 2'd0,
        retException = 2'd1,
        retEret      = 2'd2,
        retRefetch   = 2'd3
    } retireKindT;

    typedef struct packed {
        retireKindT  kind;
        logic [31:0] pc;
        logic [31:0] target;
        excCodeT     code;
    } retireRecordT;

endpackage

`default_nettype wire

// File: pipeSlot.sv
`timescale 1ns/1ps
`default_nettype none

module pipeSlot #(
    parameter type payloadT = logic [31:0]
) (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    inValid,
    output logic         inReady,
    input  wire payloadT inData,
    output logic         outValid,
    input  wire logic    outReady,
    output payloadT      outData
);

    logic    slotValid;
    payloadT slotData;

    // free when empty, or when the held item leaves this cycle
    assign inReady  = !slotValid || outReady;
    assign outValid = slotValid;
    assign outData  = slotData;

    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid <= 1'b0;
        end else if (inValid && inReady) begin
            slotValid <= 1'b1;          // refill, possibly while draining
        end else if (outReady) begin
            slotValid <= 1'b0;          // drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            slotData <= inData;
        end
    end

    // a stalled item stays put until the consumer takes it
    stallHolds: assert property (
        @(posedge clk) disable iff (rst)
        outValid && !outReady |=> outValid && $stable(outData)
    );

endmodule

`default_nettype wire

// File: cp0Regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "exc_settings.svh"

module cp0Regs (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             commitValid,
    input  wire excPkg::excCodeT  commitCode,
    input  wire logic [31:0]      commitPc,
    input  wire logic             commitDelaySlot,
    input  wire logic [31:0]      commitBadAddr,
    input  wire excPkg::cp0WriteT commitWrite,
    input  wire logic             extInterrupt,
    output logic                  statusBev,
    output logic                  statusExl,
    output logic [31:0]           ebase,
    output logic [31:0]           epc,
    output logic                  interruptPending
);
    import excPkg::*;

    localparam int BevBit = 22;
    localparam int ExlBit = 1;
    localparam int IeBit  = 0;
    localparam logic [31:0] StatusMask = 32'h0040_0003;  // BEV, EXL, IE

    logic [31:0] status;
    excCodeT     causeCode;
    logic        causeIp;       // IP2 is the one hardware line
    logic [31:0] badVAddr;
    logic        takeExc;
    logic        addrFault;
    logic        doWrite;

    assign takeExc   = commitValid && !(commitCode inside {excRefetch, excEret, excNone});
    assign addrFault = commitCode inside {excAdel, excAdes, excTlbl, excTlbs, excMod};
    // mtc0 only lands when the record really retires
    assign doWrite   = commitValid && commitWrite.en && (commitCode == excNone);

    always_ff @(posedge clk) begin
        if (rst) begin
            status <= `EXC_RESET_STATUS;
        end else if (takeExc) begin
            status[ExlBit] <= 1'b1;
        end else if (commitValid && commitCode == excEret) begin
            status[ExlBit] <= 1'b0;
        end else if (doWrite && commitWrite.sel == cp0Status) begin
            status <= commitWrite.data & StatusMask;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            causeCode <= excInt;
            causeIp   <= 1'b0;
        end else begin
            causeIp <= extInterrupt;    // level input sampled every cycle
            if (takeExc) begin
                causeCode <= commitCode;
            end else if (doWrite && commitWrite.sel == cp0Cause) begin
                causeCode <= excCodeT'(commitWrite.data[6:2]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ebase <= `EXC_RESET_EBASE;
        end else if (doWrite && commitWrite.sel == cp0Ebase) begin
            ebase <= {2'b10, commitWrite.data[29:12], 12'h000};  // top bits fixed
        end
    end

    // a nested exception keeps the first return address
    always_ff @(posedge clk) begin
        if (takeExc && !status[ExlBit]) begin
            epc <= commitDelaySlot ? commitPc - 32'd4 : commitPc;
        end else if (doWrite && commitWrite.sel == cp0Epc) begin
            epc <= commitWrite.data;
        end
    end

    always_ff @(posedge clk) begin
        if (takeExc && addrFault) begin
            badVAddr <= commitBadAddr;
        end
    end

    assign statusBev        = status[BevBit];
    assign statusExl        = status[ExlBit];
    assign interruptPending = causeIp && status[IeBit] && !status[ExlBit];

    // the resolver may only report Int while the line is pending and enabled
    intOnlyWhenPending: assert property (
        @(posedge clk) disable iff (rst)
        commitValid && commitCode == excInt |-> interruptPending
    );

    // Cause and BadVAddr describe the exception just taken
    faultRecorded: assert property (
        @(posedge clk) disable iff (rst)
        takeExc |=> causeCode == $past(commitCode)
            && (!$past(addrFault) || badVAddr == $past(commitBadAddr))
    );

endmodule

`default_nettype wire

// File: exceptionResolve.sv
`timescale 1ns/1ps
`default_nettype none

`include "exc_settings.svh"

module exceptionResolve (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              inValid,
    output logic                   inReady,
    input  wire excPkg::memRecordT inRecord,
    output logic                   outValid,
    input  wire logic              outReady,
    output excPkg::retireRecordT   outRecord,
    output logic                   commitValid,
    output excPkg::excCodeT        commitCode,
    output logic [31:0]            commitPc,
    output logic                   commitDelaySlot,
    output logic [31:0]            commitBadAddr,
    output excPkg::cp0WriteT       commitWrite,
    input  wire logic              statusBev,
    input  wire logic              statusExl,
    input  wire logic [31:0]       ebase,
    input  wire logic [31:0]       epc,
    input  wire logic              interruptPending
);
    import excPkg::*;

    excFlagsT    flags;
    tlbFaultT    tlbFault;
    excCodeT     code;
    retireKindT  kind;
    logic        isRefill;
    logic        ifFault;
    logic [31:0] base;
    logic [31:0] offset;
    logic [31:0] target;
    logic        awaiting;      // a redirect is out, target not seen yet
    logic [31:0] awaitTarget;
    logic        discard;
    logic        accept;

    assign flags    = inRecord.flags;
    assign tlbFault = inRecord.tlbFault;

    // MIPS order, refetch ahead of everything
    always_comb begin
        if (flags.refetch)                  code = excRefetch;
        else if (interruptPending)          code = excInt;
        else if (flags.wrongAddrIf)         code = excAdel;
        else if (flags.tlbRefillIf)         code = excTlbl;
        else if (flags.tlbInvalidIf)        code = excTlbl;
        else if (flags.cpUnusable)          code = excCpu;
        else if (flags.reservedInstr)       code = excRi;
        else if (flags.syscall)             code = excSys;
        else if (flags.brk)                 code = excBp;
        else if (flags.eret)                code = excEret;
        else if (flags.trap)                code = excTr;
        else if (flags.overflow)            code = excOv;
        else if (flags.wrWrongAddrMem)      code = excAdes;
        else if (flags.rdWrongAddrMem)      code = excAdel;
        else if (tlbFault == tlbRdRefill)   code = excTlbl;
        else if (tlbFault == tlbWrRefill)   code = excTlbs;
        else if (tlbFault == tlbRdInvalid)  code = excTlbl;
        else if (tlbFault == tlbWrInvalid)  code = excTlbs;
        else if (tlbFault == tlbModified)   code = excMod;
        else                                code = excNone;
    end

    // fetch faults report the pc itself as the bad address
    assign ifFault  = flags.wrongAddrIf || flags.tlbRefillIf || flags.tlbInvalidIf;
    assign isRefill = (code == excTlbl && (flags.tlbRefillIf
                          || (!flags.tlbInvalidIf && tlbFault == tlbRdRefill)))
                   || (code == excTlbs && tlbFault == tlbWrRefill);

    always_comb begin
        unique case (code)
            excNone:    kind = retCommit;
            excEret:    kind = retEret;
            excRefetch: kind = retRefetch;
            default:    kind = retException;
        endcase
    end

    assign base   = statusBev ? `EXC_BOOT_BASE : ebase;
    assign offset = (isRefill && !statusExl) ? `EXC_OFFSET_REFILL : `EXC_OFFSET_GENERAL;

    always_comb begin
        unique case (kind)
            retException: target = base + offset;
            retEret:      target = epc;
            retRefetch:   target = inRecord.pc;     // replay the same instruction
            default:      target = '0;
        endcase
    end

    // wrong-path records are swallowed without an output
    assign discard  = awaiting && inValid && (inRecord.pc != awaitTarget);
    assign outValid = inValid && !discard;
    assign inReady  = discard || outReady;
    assign accept   = outValid && outReady;

    assign outRecord = '{kind: kind, pc: inRecord.pc, target: target, code: code};

    assign commitValid     = accept;
    assign commitCode      = code;
    assign commitPc        = inRecord.pc;
    assign commitDelaySlot = inRecord.inDelaySlot;
    assign commitBadAddr   = ifFault ? inRecord.pc : inRecord.badAddr;
    assign commitWrite     = inRecord.cp0Write;

    always_ff @(posedge clk) begin
        if (rst) begin
            awaiting <= 1'b0;
        end else if (accept) begin
            awaiting <= (kind != retCommit);  // any redirect rearms the filter
        end
    end

    always_ff @(posedge clk) begin
        if (accept && kind != retCommit) begin
            awaitTarget <= target;
        end
    end

    // right after a redirect only the target pc may pass
    quietAfterRedirect: assert property (
        @(posedge clk) disable iff (rst)
        accept && kind != retCommit |=> !outValid || inRecord.pc == $past(target)
    );

endmodule

`default_nettype wire

// File: exceptionUnitTop.sv
`timescale 1ns/1ps
`default_nettype none

module exceptionUnitTop (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              inValid,
    output logic                   inReady,
    input  wire excPkg::memRecordT inRecord,
    input  wire logic              extInterrupt,
    output logic                   outValid,
    input  wire logic              outReady,
    output excPkg::retireRecordT   outRecord
);
    import excPkg::*;

    logic         headValid;
    logic         headReady;
    memRecordT    headRecord;
    logic         resValid;
    logic         resReady;
    retireRecordT resRecord;
    logic         commitValid;
    excCodeT      commitCode;
    logic [31:0]  commitPc;
    logic         commitDelaySlot;
    logic [31:0]  commitBadAddr;
    cp0WriteT     commitWrite;
    logic         statusBev;
    logic         statusExl;
    logic [31:0]  ebase;
    logic [31:0]  epc;
    logic         interruptPending;

    pipeSlot #(.payloadT(memRecordT)) i_inSlot (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (inRecord),
        .outValid (headValid),
        .outReady (headReady),
        .outData  (headRecord)
    );

    exceptionResolve i_exceptionResolve (
        .clk              (clk),
        .rst              (rst),
        .inValid          (headValid),
        .inReady          (headReady),
        .inRecord         (headRecord),
        .outValid         (resValid),
        .outReady         (resReady),
        .outRecord        (resRecord),
        .commitValid      (commitValid),
        .commitCode       (commitCode),
        .commitPc         (commitPc),
        .commitDelaySlot  (commitDelaySlot),
        .commitBadAddr    (commitBadAddr),
        .commitWrite      (commitWrite),
        .statusBev        (statusBev),
        .statusExl        (statusExl),
        .ebase            (ebase),
        .epc              (epc),
        .interruptPending (interruptPending)
    );

    cp0Regs i_cp0Regs (
        .clk              (clk),
        .rst              (rst),
        .commitValid      (commitValid),
        .commitCode       (commitCode),
        .commitPc         (commitPc),
        .commitDelaySlot  (commitDelaySlot),
        .commitBadAddr    (commitBadAddr),
        .commitWrite      (commitWrite),
        .extInterrupt     (extInterrupt),
        .statusBev        (statusBev),
        .statusExl        (statusExl),
        .ebase            (ebase),
        .epc              (epc),
        .interruptPending (interruptPending)
    );

    pipeSlot #(.payloadT(retireRecordT)) i_outSlot (
        .clk      (clk),
        .rst      (rst),
        .inValid  (resValid),
        .inReady  (resReady),
        .inData   (resRecord),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outRecord)
    );

endmodule

`default_nettype wire

// File: tbExceptionUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exc_settings.svh"

module tbExceptionUnit;
    import excPkg::*;

    localparam int ClkPeriod   = 100;
    localparam int SampleDelay = 40;    // sample just before the rising edge
    localparam logic [31:0] ResetStatus = `EXC_RESET_STATUS;
    localparam logic [31:0] NewEbase    = 32'h8001_0000;
    localparam logic [31:0] VecBoot     = `EXC_BOOT_BASE + `EXC_OFFSET_GENERAL;
    localparam logic [31:0] VecGeneral  = NewEbase + `EXC_OFFSET_GENERAL;
    localparam logic [31:0] VecRefill   = NewEbase + `EXC_OFFSET_REFILL;

    typedef struct packed {
        logic      irq;
        logic      expDrop;     // wrong path is consumed without output
        excCodeT   expCode;
        memRecordT rec;
    } stimT;

    logic         clk = 1'b0;
    logic         rst;
    logic         inValid;
    logic         inReady;
    memRecordT    inRecord;
    logic         extInterrupt;
    logic         outValid;
    logic         outReady = 1'b0;
    retireRecordT outRecord;

    stimT         stimQ[$];
    retireRecordT expQ[$];
    excCodeT      codeQ[$];
    int           predicted;
    int           retired;
    logic         tableBuilt = 1'b0;

    // reference model state
    logic         mBev;
    logic         mExl;
    logic         mIe;
    logic [31:0]  mEbase;
    logic [31:0]  mEpc;
    logic         mAwaiting;
    logic [31:0]  mAwaitTarget;
    excCodeT      mCode;
    logic         mRefill;
    logic         mFound;

    exceptionUnitTop i_exceptionUnitTop (
        .clk          (clk),
        .rst          (rst),
        .inValid      (inValid),
        .inReady      (inReady),
        .inRecord     (inRecord),
        .extInterrupt (extInterrupt),
        .outValid     (outValid),
        .outReady     (outReady),
        .outRecord    (outRecord)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    task failRun(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic checkCode(input excCodeT got, input excCodeT exp);
        if (got !== exp) begin
            failRun($sformatf("code %s, table expects %s", got.name(), exp.name()));
        end
    endtask

    task automatic checkRetire(input retireRecordT got, input retireRecordT exp);
        if (got !== exp) begin
            failRun($sformatf("pc %h kind %s target %h, expected pc %h kind %s target %h",
                got.pc, got.kind.name(), got.target, exp.pc, exp.kind.name(), exp.target));
        end
    endtask

    // random back-pressure and output checking
    initial begin
        void'($urandom(32'h11ac));
        forever begin
            @(negedge clk);
            outReady = ($urandom % 4) != 0;     // ready about three cycles in four
            #(SampleDelay);
            if (!rst && outValid && outReady) begin
                if (expQ.size() == 0) begin
                    failRun($sformatf("retire record for pc %h with none expected",
                        outRecord.pc));
                end else begin
                    checkCode(outRecord.code, codeQ.pop_front());
                    checkRetire(outRecord, expQ.pop_front());
                    retired++;
                end
            end
        end
    end

    task automatic add(input logic [31:0] pc, input excFlagsT f, input tlbFaultT t,
                       input logic ds, input cp0WriteT w, input logic irq, input excCodeT c);
        stimT s;
        s.rec.pc          = pc;
        s.rec.flags       = f;
        s.rec.tlbFault    = t;
        s.rec.badAddr     = pc ^ 32'h0000_0ff0;
        s.rec.inDelaySlot = ds;
        s.rec.cp0Write    = w;
        s.irq             = irq;
        s.expDrop         = 1'b0;
        s.expCode         = c;
        stimQ.push_back(s);
    endtask

    task automatic addWrong(input logic [31:0] pc);
        stimT s;
        s         = '0;
        s.rec.pc  = pc;
        s.expDrop = 1'b1;
        s.expCode = excNone;
        stimQ.push_back(s);
    endtask

    task automatic plain(input logic [31:0] pc);
        add(pc, '0, tlbNone, 1'b0, '0, 1'b0, excNone);
    endtask

    // fault, handler doing eret, then the resumed instruction
    task automatic roundTrip(input logic [31:0] pc, input excFlagsT f, input tlbFaultT t,
                             input logic ds, input logic [31:0] vec, input int nWrong,
                             input excCodeT c);
        add(pc, f, t, ds, '0, 1'b0, c);
        for (int k = 1; k <= nWrong; k++) begin
            addWrong(pc + 4 * k);
        end
        add(vec, excFlagsT'{eret: 1'b1, default: 1'b0}, tlbNone, 1'b0, '0, 1'b0, excEret);
        for (int k = 1; k <= nWrong; k++) begin
            addWrong(vec + 4 * k);
        end
        plain(ds ? pc - 4 : pc);
    endtask

    task automatic buildTable();
        for (int i = 0; i < 10; i++) begin
            plain(32'h0040_0000 + 4 * i);
        end
        add(32'h0040_0028, excFlagsT'{refetch: 1'b1, wrongAddrIf: 1'b1, default: 1'b0},
            tlbNone, 1'b0, '0, 1'b0, excRefetch);
        addWrong(32'h0040_002c);
        addWrong(32'h0040_0030);
        plain(32'h0040_0028);
        // priority pairs with BEV still set
        roundTrip(32'h0040_0100, excFlagsT'{wrongAddrIf: 1'b1, cpUnusable: 1'b1, default: 1'b0},
            tlbRdRefill, 1'b0, VecBoot, 1, excAdel);
        roundTrip(32'h0040_0110,
            excFlagsT'{tlbInvalidIf: 1'b1, reservedInstr: 1'b1, default: 1'b0},
            tlbNone, 1'b0, VecBoot, 0, excTlbl);
        roundTrip(32'h0040_0120,
            excFlagsT'{cpUnusable: 1'b1, reservedInstr: 1'b1, brk: 1'b1, default: 1'b0},
            tlbNone, 1'b0, VecBoot, 0, excCpu);
        roundTrip(32'h0040_0130,
            excFlagsT'{syscall: 1'b1, trap: 1'b1, overflow: 1'b1, default: 1'b0},
            tlbNone, 1'b1, VecBoot, 2, excSys);
        roundTrip(32'h0040_0140, excFlagsT'{brk: 1'b1, trap: 1'b1, default: 1'b0},
            tlbNone, 1'b0, VecBoot, 0, excBp);
        roundTrip(32'h0040_0150, excFlagsT'{trap: 1'b1, overflow: 1'b1, default: 1'b0},
            tlbNone, 1'b0, VecBoot, 0, excTr);
        roundTrip(32'h0040_0160, excFlagsT'{overflow: 1'b1, wrWrongAddrMem: 1'b1, default: 1'b0},
            tlbNone, 1'b0, VecBoot, 0, excOv);
        roundTrip(32'h0040_0170,
            excFlagsT'{wrWrongAddrMem: 1'b1, rdWrongAddrMem: 1'b1, default: 1'b0},
            tlbWrInvalid, 1'b0, VecBoot, 0, excAdes);
        roundTrip(32'h0040_0180, excFlagsT'{rdWrongAddrMem: 1'b1, default: 1'b0},
            tlbRdInvalid, 1'b0, VecBoot, 0, excAdel);
        roundTrip(32'h0040_0190, '0, tlbModified, 1'b0, VecBoot, 1, excMod);
        roundTrip(32'h0040_01a0, excFlagsT'{reservedInstr: 1'b1, syscall: 1'b1, default: 1'b0},
            tlbNone, 1'b0, VecBoot, 0, excRi);
        // nested exception keeps EPC
        add(32'h0040_0200, excFlagsT'{syscall: 1'b1, default: 1'b0}, tlbNone, 1'b0, '0, 1'b0,
            excSys);
        add(VecBoot, excFlagsT'{brk: 1'b1, default: 1'b0}, tlbNone, 1'b0, '0, 1'b0, excBp);
        add(VecBoot, excFlagsT'{eret: 1'b1, default: 1'b0}, tlbNone, 1'b0, '0, 1'b0, excEret);
        plain(32'h0040_0200);
        add(32'h0040_0300, '0, tlbNone, 1'b0, '0, 1'b1, excNone);   // IE still clear
        add(32'h0040_0304, '0, tlbNone, 1'b0,
            cp0WriteT'{en: 1'b1, sel: cp0Ebase, data: NewEbase}, 1'b0, excNone);
        add(32'h0040_0308, '0, tlbNone, 1'b0,
            cp0WriteT'{en: 1'b1, sel: cp0Status, data: 32'h0000_0001}, 1'b0, excNone);
        // interrupt beats RI, then ignored inside the handler
        add(32'h0040_0310, excFlagsT'{reservedInstr: 1'b1, default: 1'b0}, tlbNone, 1'b0, '0,
            1'b1, excInt);
        add(VecGeneral, '0, tlbNone, 1'b0, '0, 1'b1, excNone);
        add(VecGeneral + 4, excFlagsT'{eret: 1'b1, default: 1'b0}, tlbNone, 1'b0, '0, 1'b0,
            excEret);
        plain(32'h0040_0310);
        // refill vector only while EXL is clear
        add(32'h0040_0400, excFlagsT'{tlbRefillIf: 1'b1, default: 1'b0}, tlbNone, 1'b0, '0,
            1'b0, excTlbl);
        add(VecRefill, '0, tlbRdRefill, 1'b0, '0, 1'b0, excTlbl);
        add(VecGeneral, excFlagsT'{eret: 1'b1, default: 1'b0}, tlbNone, 1'b0, '0, 1'b0,
            excEret);
        plain(32'h0040_0400);
        roundTrip(32'h0040_0410, '0, tlbWrRefill, 1'b1, VecRefill, 2, excTlbs);
        for (int i = 0; i < 6; i++) begin
            plain(32'h0040_0500 + 4 * i);
        end
    endtask

    task automatic take(input logic cond, input excCodeT c, input logic refill);
        if (cond && !mFound) begin
            mCode   = c;
            mRefill = refill;
            mFound  = 1'b1;
        end
    endtask

    task automatic predict(input stimT s);
        memRecordT    r;
        retireRecordT exp;
        logic         drop;
        r    = s.rec;
        drop = mAwaiting && (r.pc != mAwaitTarget);
        if (drop != s.expDrop) begin
            failRun($sformatf("model and table disagree on discarding pc %h", r.pc));
        end else if (!drop) begin
            mFound  = 1'b0;
            mCode   = excNone;
            mRefill = 1'b0;
            take(r.flags.refetch, excRefetch, 1'b0);
            take(s.irq && mIe && !mExl, excInt, 1'b0);
            take(r.flags.wrongAddrIf, excAdel, 1'b0);
            take(r.flags.tlbRefillIf, excTlbl, 1'b1);
            take(r.flags.tlbInvalidIf, excTlbl, 1'b0);
            take(r.flags.cpUnusable, excCpu, 1'b0);
            take(r.flags.reservedInstr, excRi, 1'b0);
            take(r.flags.syscall, excSys, 1'b0);
            take(r.flags.brk, excBp, 1'b0);
            take(r.flags.eret, excEret, 1'b0);
            take(r.flags.trap, excTr, 1'b0);
            take(r.flags.overflow, excOv, 1'b0);
            take(r.flags.wrWrongAddrMem, excAdes, 1'b0);
            take(r.flags.rdWrongAddrMem, excAdel, 1'b0);
            take(r.tlbFault == tlbRdRefill, excTlbl, 1'b1);
            take(r.tlbFault == tlbRdInvalid, excTlbl, 1'b0);
            take(r.tlbFault == tlbWrRefill, excTlbs, 1'b1);
            take(r.tlbFault == tlbWrInvalid, excTlbs, 1'b0);
            take(r.tlbFault == tlbModified, excMod, 1'b0);
            exp.pc   = r.pc;
            exp.code = mCode;
            case (mCode)
                excNone: begin
                    exp.kind   = retCommit;
                    exp.target = '0;
                end
                excEret: begin
                    exp.kind   = retEret;
                    exp.target = mEpc;
                end
                excRefetch: begin
                    exp.kind   = retRefetch;
                    exp.target = r.pc;
                end
                default: begin
                    exp.kind   = retException;
                    exp.target = (mBev ? `EXC_BOOT_BASE : mEbase)
                        + ((mRefill && !mExl) ? `EXC_OFFSET_REFILL : `EXC_OFFSET_GENERAL);
                end
            endcase
            if (exp.kind == retException) begin
                if (!mExl) begin
                    mEpc = r.inDelaySlot ? r.pc - 4 : r.pc;
                end
                mExl = 1'b1;
            end else if (exp.kind == retEret) begin
                mExl = 1'b0;
            end else if (exp.kind == retCommit && r.cp0Write.en) begin
                case (r.cp0Write.sel)
                    cp0Status: begin
                        mBev = r.cp0Write.data[22];
                        mExl = r.cp0Write.data[1];
                        mIe  = r.cp0Write.data[0];
                    end
                    cp0Ebase: mEbase = r.cp0Write.data;
                    cp0Epc:   mEpc = r.cp0Write.data;
                    default:  ;     // Cause has no visible effect here
                endcase
            end
            mAwaiting    = exp.kind != retCommit;
            mAwaitTarget = exp.target;
            expQ.push_back(exp);
            codeQ.push_back(s.expCode);
            predicted++;
        end
    endtask

    // called at a falling edge, returns at the falling edge after the transfer
    task automatic sendRecord(input memRecordT r);
        logic taken;
        inValid  = 1'b1;
        inRecord = r;
        do begin
            #(SampleDelay);
            taken = inReady;
            @(negedge clk);
        end while (!taken);
        inValid = 1'b0;
    endtask

    task automatic drain();
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);     // discarded records leave as well
    endtask

    initial begin
        rst          = 1'b1;
        inValid      = 1'b0;
        inRecord     = '0;
        extInterrupt = 1'b0;
        mBev         = ResetStatus[22];
        mExl         = ResetStatus[1];
        mIe          = ResetStatus[0];
        mEbase       = `EXC_RESET_EBASE;
        mEpc         = '0;
        mAwaiting    = 1'b0;
        mAwaitTarget = '0;
        predicted    = 0;
        retired      = 0;
        buildTable();
        tableBuilt = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < stimQ.size(); i++) begin
            if (stimQ[i].irq) begin
                drain();                    // interrupt meets this record alone
                extInterrupt = 1'b1;
                repeat (2) @(negedge clk);  // Cause.IP follows one edge later
            end
            predict(stimQ[i]);
            sendRecord(stimQ[i].rec);
            if (stimQ[i].irq) begin
                drain();
                extInterrupt = 1'b0;
                repeat (2) @(negedge clk);
            end
        end
        drain();
        if (outValid) begin
            $display("retire record for pc %h left over after the last table entry",
                outRecord.pc);
            $display("Something failed");
            $fatal(1);
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

    // watchdog allows 40 cycles per table entry
    initial begin
        wait (tableBuilt);
        repeat (stimQ.size() * 40 + 8) @(posedge clk);
        $display("timeout: only %0d of %0d retire records arrived", retired, predicted);
        $display("Something failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
excPkg.sv
pipeSlot.sv
cp0Regs.sv
exceptionResolve.sv
exceptionUnitTop.sv
tbExceptionUnit.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the exception unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tbExceptionUnit -f all.f -o simExceptionUnit
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/simExceptionUnit 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -Fqx "Everything OK"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
